// File: include/radio_cfg.svh
/*
 * Settings bus map and reset defaults of the radio control block.
 * Addresses are 8 bits wide; the ATR block takes five and the time block three.
 */
`ifndef RADIO_CFG_SVH
`define RADIO_CFG_SVH

// Setting addresses
`define RADIO_SR_LOOPBACK     8'd6
`define RADIO_SR_ATR          8'd12   // Idle, rx, tx, fdx, ddr at 12..16
`define RADIO_SR_TEST         8'd21
`define RADIO_SR_CODEC_IDLE   8'd22
`define RADIO_SR_READBACK     8'd32
`define RADIO_SR_TIME         8'd128  // Hi, lo, ctrl at 128..130

// Readback codes
`define RADIO_RB_TEST         3'd0
`define RADIO_RB_TIME         3'd1
`define RADIO_RB_LASTPPS      3'd2
`define RADIO_RB_SAMPLES      3'd3
`define RADIO_RB_GPIO         3'd4

// Front-end GPIO reset values, pins are outputs by default
`define RADIO_ATR_DEFAULT_DDR  32'hFFFF_FFFF
`define RADIO_ATR_DEFAULT_IDLE 32'h0000_0000

`endif

// File: logic/radio_bus_pkg.sv
/*
 * Settings bus and readback types.
 * A write is one cycle of stb with addr and data valid together.
 */
package radio_bus_pkg;

   // One settings write, 41 bits
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef logic [2:0]  rb_addr_t;    // Readback selector
   typedef logic [63:0] rb_word_t;
   typedef logic [63:0] vita_time_t;

   // Control registers handed to the datapaths, 36 bits
   typedef struct packed {
      logic        loopback;
      logic [31:0] codec_idle;
      rb_addr_t    rb_addr;
   } radio_ctl_t;

endpackage

// File: logic/radio_fe_pkg.sv
/*
 * Front-end sample, GPIO and ATR types.
 * Samples are 16-bit I and Q packed into one 32-bit word.
 */
package radio_fe_pkg;

   typedef struct packed {
      logic [15:0] i;   // Upper half
      logic [15:0] q;   // Lower half
   } iq_sample_t;

   typedef logic [31:0] gpio_word_t;

   // GPIO pins as driven to the front end
   typedef struct packed {
      gpio_word_t out;
      gpio_word_t ddr;
   } gpio_fe_t;

   // Encoded as {run_tx, run_rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_e;

endpackage

// File: logic/radio_settings.sv
/*
 * Settings bus register and the radio control registers.
 * Every datapath decodes the registered bus, so writes land one edge later.
 */
`timescale 1ns/1ps
`include "radio_cfg.svh"

module radio_settings (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  radio_bus_pkg::set_bus_t   i_set,
   output radio_bus_pkg::set_bus_t   o_set_r,
   output radio_bus_pkg::radio_ctl_t o_ctl,
   output logic [31:0]               o_test_value
);

   logic                     loopback;
   logic [31:0]              codec_idle;
   radio_bus_pkg::rb_addr_t  rb_addr;
   logic                     wr_loopback;
   logic                     wr_test;
   logic                     wr_idle;
   logic                     wr_rb;

   // Bus register, shared by all decoders
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_set_r <= '0;
      end else begin
         o_set_r <= i_set;
      end
   end

   assign wr_loopback = o_set_r.stb && (o_set_r.addr == `RADIO_SR_LOOPBACK);
   assign wr_test     = o_set_r.stb && (o_set_r.addr == `RADIO_SR_TEST);
   assign wr_idle     = o_set_r.stb && (o_set_r.addr == `RADIO_SR_CODEC_IDLE);
   assign wr_rb       = o_set_r.stb && (o_set_r.addr == `RADIO_SR_READBACK);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         loopback     <= 1'b0;
         o_test_value <= '0;
         codec_idle   <= '0;
         rb_addr      <= '0;
      end else begin
         if (wr_loopback) loopback <= o_set_r.data[0];
         if (wr_test) o_test_value <= o_set_r.data;
         if (wr_idle) codec_idle <= o_set_r.data;   // Sent while TX is stopped
         if (wr_rb) rb_addr <= o_set_r.data[2:0];
      end
   end

   assign o_ctl.loopback   = loopback;
   assign o_ctl.codec_idle = codec_idle;
   assign o_ctl.rb_addr    = rb_addr;

endmodule

// File: logic/timekeeper.sv
/*
 * 64-bit time counter, one tick per bus_clk cycle.
 * Ctrl bit 0 low loads {hi, lo} now, high arms a load at the next PPS edge.
 * A PPS edge in the same cycle as the arming write is not used for the load.
 */
`timescale 1ns/1ps
`include "radio_cfg.svh"

module timekeeper (
   input  logic                      bus_clk,
   input  logic                      i_rst,
   input  radio_bus_pkg::set_bus_t   i_set_r,
   input  logic                      i_pps,
   output radio_bus_pkg::vita_time_t o_vita_time,
   output radio_bus_pkg::vita_time_t o_vita_time_lastpps
);

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        armed;
   logic        pps_d;
   logic        pps_edge;
   logic        wr_hi;
   logic        wr_lo;
   logic        wr_ctrl;

   assign wr_hi   = i_set_r.stb && (i_set_r.addr == `RADIO_SR_TIME);
   assign wr_lo   = i_set_r.stb && (i_set_r.addr == `RADIO_SR_TIME + 8'd1);
   assign wr_ctrl = i_set_r.stb && (i_set_r.addr == `RADIO_SR_TIME + 8'd2);

   assign pps_edge = i_pps && !pps_d;   // High now, low last cycle

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         time_hi             <= '0;
         time_lo             <= '0;
         armed               <= 1'b0;
         pps_d               <= 1'b0;
         o_vita_time         <= '0;
         o_vita_time_lastpps <= '0;
      end else begin
         pps_d <= i_pps;
         if (wr_hi) time_hi <= i_set_r.data;
         if (wr_lo) time_lo <= i_set_r.data;

         // Time as it stood just before the edge
         if (pps_edge) o_vita_time_lastpps <= o_vita_time;

         if (wr_ctrl && !i_set_r.data[0]) begin
            o_vita_time <= {time_hi, time_lo};
         end else if (armed && pps_edge) begin
            o_vita_time <= {time_hi, time_lo};
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end

         if (wr_ctrl) begin
            armed <= i_set_r.data[0];   // Set-now also cancels a pending load
         end else if (pps_edge) begin
            armed <= 1'b0;
         end
      end
   end

endmodule

// File: logic/gpio_atr.sv
/*
 * Front-end GPIO automatic transmit/receive.
 * Registers at SR_ATR+0..4 are idle, rx, tx, full duplex and ddr.
 * Pins follow the run levels one cycle later.
 */
`timescale 1ns/1ps
`include "radio_cfg.svh"

module gpio_atr (
   input  logic                    bus_clk,
   input  logic                    i_rst,
   input  radio_bus_pkg::set_bus_t i_set_r,
   input  logic                    i_run_rx,
   input  logic                    i_run_tx,
   output radio_fe_pkg::gpio_fe_t  o_fe_gpio
);

   radio_fe_pkg::gpio_word_t atr_idle;
   radio_fe_pkg::gpio_word_t atr_rx;
   radio_fe_pkg::gpio_word_t atr_tx;
   radio_fe_pkg::gpio_word_t atr_fdx;
   radio_fe_pkg::gpio_word_t ddr;
   radio_fe_pkg::gpio_word_t atr_word;
   radio_fe_pkg::atr_state_e atr_state;
   logic [7:0]               offset;

   assign offset = i_set_r.addr - `RADIO_SR_ATR;   // Wraps high below the base

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         atr_idle <= `RADIO_ATR_DEFAULT_IDLE;
         atr_rx   <= '0;
         atr_tx   <= '0;
         atr_fdx  <= '0;
         ddr      <= `RADIO_ATR_DEFAULT_DDR;
      end else if (i_set_r.stb) begin
         case (offset)
            8'd0: atr_idle <= i_set_r.data;
            8'd1: atr_rx   <= i_set_r.data;
            8'd2: atr_tx   <= i_set_r.data;
            8'd3: atr_fdx  <= i_set_r.data;
            8'd4: ddr      <= i_set_r.data;
            default: ;
         endcase
      end
   end

   assign atr_state = radio_fe_pkg::atr_state_e'({i_run_tx, i_run_rx});

   always_comb begin
      case (atr_state)
         radio_fe_pkg::ATR_RX:  atr_word = atr_rx;
         radio_fe_pkg::ATR_TX:  atr_word = atr_tx;
         radio_fe_pkg::ATR_FDX: atr_word = atr_fdx;
         default:               atr_word = atr_idle;
      endcase
   end

   // Pin register
   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         o_fe_gpio.out <= `RADIO_ATR_DEFAULT_IDLE;
         o_fe_gpio.ddr <= `RADIO_ATR_DEFAULT_DDR;
      end else begin
         o_fe_gpio.out <= atr_word;
         o_fe_gpio.ddr <= ddr;
      end
   end

endmodule

// File: logic/fe_sample_path.sv
/*
 * TX output register and RX loopback select, one register stage each.
 * Loopback takes the registered TX word, so RX sees it one cycle after TX.
 */
`timescale 1ns/1ps

module fe_sample_path (
   input  logic                      bus_clk,
   input  logic                      i_rst,
   input  radio_bus_pkg::radio_ctl_t i_ctl,
   input  logic                      i_run_tx,
   input  radio_fe_pkg::iq_sample_t  i_tx_sample,
   input  radio_fe_pkg::iq_sample_t  i_rx,
   output radio_fe_pkg::iq_sample_t  o_tx,
   output radio_fe_pkg::iq_sample_t  o_rx_fe
);

   radio_fe_pkg::iq_sample_t idle_word;

   assign idle_word = radio_fe_pkg::iq_sample_t'(i_ctl.codec_idle);

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         o_tx    <= '0;
         o_rx_fe <= '0;
      end else begin
         o_tx    <= i_run_tx ? i_tx_sample : idle_word;   // Idle word when TX stops
         o_rx_fe <= i_ctl.loopback ? o_tx : i_rx;
      end
   end

endmodule

// File: logic/readback_mux.sv
/*
 * Registered readback word, selected by the readback address register.
 * Unused codes read as zero.
 */
`timescale 1ns/1ps
`include "radio_cfg.svh"

module readback_mux (
   input  logic                      bus_clk,
   input  logic                      i_rst,
   input  radio_bus_pkg::radio_ctl_t i_ctl,
   input  logic [31:0]               i_test_value,
   input  radio_bus_pkg::vita_time_t i_vita_time,
   input  radio_bus_pkg::vita_time_t i_vita_time_lastpps,
   input  radio_fe_pkg::iq_sample_t  i_tx,
   input  radio_fe_pkg::iq_sample_t  i_rx,
   input  radio_fe_pkg::gpio_word_t  i_fe_gpio_in,
   output radio_bus_pkg::rb_word_t   o_rb_data
);

   radio_bus_pkg::rb_word_t rb_next;

   always_comb begin
      case (i_ctl.rb_addr)
         `RADIO_RB_TEST:    rb_next = {32'd0, i_test_value};
         `RADIO_RB_TIME:    rb_next = i_vita_time;
         `RADIO_RB_LASTPPS: rb_next = i_vita_time_lastpps;
         `RADIO_RB_SAMPLES: rb_next = {i_tx, i_rx};       // TX in the upper word
         `RADIO_RB_GPIO:    rb_next = {32'd0, i_fe_gpio_in};
         default:           rb_next = '0;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         o_rb_data <= '0;
      end else begin
         o_rb_data <= rb_next;
      end
   end

endmodule

// File: logic/radio_ctrl_top.sv
/*
 * Radio settings and front-end control, single bus_clk domain.
 * Run levels and the TX sample come straight from the ports, no handshake.
 */
`timescale 1ns/1ps

module radio_ctrl_top (
   input  logic                      bus_clk,
   input  logic                      i_rst,
   input  radio_bus_pkg::set_bus_t   i_set,
   input  logic                      i_pps,
   input  radio_fe_pkg::iq_sample_t  i_rx,
   input  radio_fe_pkg::iq_sample_t  i_tx_sample,
   input  logic                      i_run_rx,
   input  logic                      i_run_tx,
   input  radio_fe_pkg::gpio_word_t  i_fe_gpio_in,
   output radio_fe_pkg::iq_sample_t  o_tx,
   output radio_fe_pkg::iq_sample_t  o_rx_fe,
   output radio_fe_pkg::gpio_fe_t    o_fe_gpio,
   output radio_bus_pkg::vita_time_t o_vita_time,
   output radio_bus_pkg::rb_word_t   o_rb_data
);

   radio_bus_pkg::set_bus_t   set_r;
   radio_bus_pkg::radio_ctl_t ctl;
   logic [31:0]               test_value;
   radio_bus_pkg::vita_time_t vita_time_lastpps;

   ////////////////////////////////////////////////////////////
   // Settings and time

   radio_settings u_settings (
      .i_clk(bus_clk), .i_rst(i_rst), .i_set(i_set),
      .o_set_r(set_r), .o_ctl(ctl), .o_test_value(test_value)
   );

   timekeeper u_timekeeper (
      .bus_clk(bus_clk), .i_rst(i_rst), .i_set_r(set_r), .i_pps(i_pps),
      .o_vita_time(o_vita_time), .o_vita_time_lastpps(vita_time_lastpps)
   );

   ////////////////////////////////////////////////////////////
   // Front end

   gpio_atr u_fe_gpio_atr (
      .bus_clk(bus_clk), .i_rst(i_rst), .i_set_r(set_r),
      .i_run_rx(i_run_rx), .i_run_tx(i_run_tx), .o_fe_gpio(o_fe_gpio)
   );

   fe_sample_path u_sample_path (
      .bus_clk(bus_clk), .i_rst(i_rst), .i_ctl(ctl), .i_run_tx(i_run_tx),
      .i_tx_sample(i_tx_sample), .i_rx(i_rx), .o_tx(o_tx), .o_rx_fe(o_rx_fe)
   );

   readback_mux u_readback (
      .bus_clk(bus_clk), .i_rst(i_rst), .i_ctl(ctl), .i_test_value(test_value),
      .i_vita_time(o_vita_time), .i_vita_time_lastpps(vita_time_lastpps),
      .i_tx(o_tx), .i_rx(i_rx), .i_fe_gpio_in(i_fe_gpio_in),
      .o_rb_data(o_rb_data)
   );

endmodule

// File: testbench/radio_ctrl_tb.sv
/*
 * Testbench for radio_ctrl_top with seeded random writes, samples and PPS.
 * A cycle model steps on each rising edge; outputs are checked on the falling edge.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ps
`include "radio_cfg.svh"

module radio_ctrl_tb;

   localparam int RST_CYCLES = 5;
   localparam int NUM_CYCLES = 2000;
   localparam int LIMIT      = RST_CYCLES + NUM_CYCLES + 100;

   logic                      bus_clk;
   logic                      rst;
   radio_bus_pkg::set_bus_t   set_in;
   logic                      pps_in;
   radio_fe_pkg::iq_sample_t  rx_in;
   radio_fe_pkg::iq_sample_t  tx_in;
   logic                      run_rx;
   logic                      run_tx;
   radio_fe_pkg::gpio_word_t  gpio_in;
   radio_fe_pkg::iq_sample_t  o_tx;
   radio_fe_pkg::iq_sample_t  o_rx_fe;
   radio_fe_pkg::gpio_fe_t    o_fe_gpio;
   radio_bus_pkg::vita_time_t o_vita_time;
   radio_bus_pkg::rb_word_t   o_rb_data;

   // Model state
   radio_bus_pkg::set_bus_t   m_set_r;
   logic                      m_loopback;
   logic [31:0]               m_test;
   logic [31:0]               m_idle;
   radio_bus_pkg::rb_addr_t   m_rb_addr;
   logic [31:0]               m_hi;
   logic [31:0]               m_lo;
   logic                      m_armed;
   logic                      m_pps_d;
   radio_bus_pkg::vita_time_t m_time;
   radio_bus_pkg::vita_time_t m_lastpps;
   radio_fe_pkg::gpio_word_t  m_atr [4];   // Indexed by {run_tx, run_rx}
   radio_fe_pkg::gpio_word_t  m_ddr;
   radio_fe_pkg::gpio_fe_t    m_gpio;
   radio_fe_pkg::iq_sample_t  m_tx;
   radio_fe_pkg::iq_sample_t  m_rx_fe;
   radio_bus_pkg::rb_word_t   m_rb;
   int                        cycle_cnt;
   int                        pps_gap;
   int                        rand_seed;

   radio_ctrl_top UUT (
      .bus_clk(bus_clk), .i_rst(rst), .i_set(set_in), .i_pps(pps_in),
      .i_rx(rx_in), .i_tx_sample(tx_in), .i_run_rx(run_rx), .i_run_tx(run_tx),
      .i_fe_gpio_in(gpio_in), .o_tx(o_tx), .o_rx_fe(o_rx_fe),
      .o_fe_gpio(o_fe_gpio), .o_vita_time(o_vita_time), .o_rb_data(o_rb_data)
   );

   initial begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk) cycle_cnt <= cycle_cnt + 1;

   initial begin
      wait (cycle_cnt >= LIMIT);
      $display("Timeout: the test ran past %0d cycles", LIMIT);
      $display("Done: errors found");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      $display("Done: errors found");
      $fatal(1, "output mismatch");
   endtask

   task automatic check_iq(input string name, input radio_fe_pkg::iq_sample_t exp,
                           input radio_fe_pkg::iq_sample_t act);
      if (act !== exp) report_mismatch(name, {32'd0, exp}, {32'd0, act});
   endtask

   task automatic check_gpio(input string name, input radio_fe_pkg::gpio_fe_t exp,
                             input radio_fe_pkg::gpio_fe_t act);
      if (act !== exp) report_mismatch(name, exp, act);
   endtask

   task automatic check_time(input string name, input radio_bus_pkg::vita_time_t exp,
                             input radio_bus_pkg::vita_time_t act);
      if (act !== exp) report_mismatch(name, exp, act);
   endtask

   task automatic check_rb(input string name, input radio_bus_pkg::rb_word_t exp,
                           input radio_bus_pkg::rb_word_t act);
      if (act !== exp) report_mismatch(name, exp, act);
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle model that turns old state into new state

   task automatic model_step();
      logic        edge_seen;
      logic        wr;
      logic [7:0]  a;
      logic [31:0] d;
      logic [7:0]  ofs;
      edge_seen = pps_in && !m_pps_d;
      wr = m_set_r.stb;
      a = m_set_r.addr;
      d = m_set_r.data;
      ofs = a - `RADIO_SR_ATR;
      if (rst) begin
         m_loopback = 1'b0;
         m_test = '0;
         m_idle = '0;
         m_rb_addr = '0;
         m_hi = '0;
         m_lo = '0;
         m_armed = 1'b0;
         m_pps_d = 1'b0;
         m_time = '0;
         m_lastpps = '0;
         m_atr = '{`RADIO_ATR_DEFAULT_IDLE, 32'd0, 32'd0, 32'd0};
         m_ddr = `RADIO_ATR_DEFAULT_DDR;
         m_gpio = {`RADIO_ATR_DEFAULT_IDLE, `RADIO_ATR_DEFAULT_DDR};
         m_tx = '0;
         m_rx_fe = '0;
         m_rb = '0;
         m_set_r = '0;
      end else begin
         case (m_rb_addr)   // Sources as they stood before this edge
            `RADIO_RB_TEST:    m_rb = {32'd0, m_test};
            `RADIO_RB_TIME:    m_rb = m_time;
            `RADIO_RB_LASTPPS: m_rb = m_lastpps;
            `RADIO_RB_SAMPLES: m_rb = {m_tx, rx_in};
            `RADIO_RB_GPIO:    m_rb = {32'd0, gpio_in};
            default:           m_rb = '0;
         endcase
         m_rx_fe = m_loopback ? m_tx : rx_in;   // Loopback sees the old TX word
         m_tx = run_tx ? tx_in : radio_fe_pkg::iq_sample_t'(m_idle);
         m_gpio.out = m_atr[{run_tx, run_rx}];
         m_gpio.ddr = m_ddr;
         if (wr && ofs < 8'd4) m_atr[ofs[1:0]] = d;
         if (wr && ofs == 8'd4) m_ddr = d;

         // Timekeeper
         if (edge_seen) m_lastpps = m_time;
         if (wr && a == `RADIO_SR_TIME + 8'd2 && !d[0]) m_time = {m_hi, m_lo};
         else if (m_armed && edge_seen) m_time = {m_hi, m_lo};
         else m_time = m_time + 64'd1;
         if (wr && a == `RADIO_SR_TIME + 8'd2) m_armed = d[0];
         else if (edge_seen) m_armed = 1'b0;
         if (wr && a == `RADIO_SR_TIME) m_hi = d;
         if (wr && a == `RADIO_SR_TIME + 8'd1) m_lo = d;
         m_pps_d = pps_in;

         // Control registers
         if (wr && a == `RADIO_SR_LOOPBACK) m_loopback = d[0];
         if (wr && a == `RADIO_SR_TEST) m_test = d;
         if (wr && a == `RADIO_SR_CODEC_IDLE) m_idle = d;
         if (wr && a == `RADIO_SR_READBACK) m_rb_addr = d[2:0];
         m_set_r = set_in;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus

   function automatic logic [7:0] pick_addr();
      int sel;
      sel = $urandom_range(0, 15);
      if (sel == 0) return `RADIO_SR_LOOPBACK;
      if (sel == 1) return `RADIO_SR_TEST;
      if (sel == 2) return `RADIO_SR_CODEC_IDLE;
      if (sel <= 4) return `RADIO_SR_READBACK;
      if (sel <= 9) return `RADIO_SR_ATR + 8'(sel - 5);
      if (sel <= 12) return `RADIO_SR_TIME + 8'(sel - 10);
      return 8'($urandom);   // Mostly unmapped
   endfunction

   task automatic drive_inputs(input int cyc);
      radio_bus_pkg::set_bus_t s;
      s.stb = ($urandom_range(0, 2) == 0);
      s.addr = pick_addr();
      s.data = $urandom;
      set_in <= s;
      rst <= (cyc < RST_CYCLES - 1);
      rx_in <= $urandom;
      tx_in <= $urandom;
      gpio_in <= $urandom;
      if ($urandom_range(0, 3) == 0) run_rx <= $urandom_range(0, 1);
      if ($urandom_range(0, 3) == 0) run_tx <= $urandom_range(0, 1);
      // One-cycle PPS pulses with at least 3 low cycles between them
      if (pps_in) begin
         pps_in <= 1'b0;
         pps_gap = 0;
      end else begin
         pps_gap = pps_gap + 1;
         if (pps_gap >= 3 && $urandom_range(0, 9) == 0) pps_in <= 1'b1;
      end
   endtask

   initial begin
      rand_seed = 53;
      void'($urandom(rand_seed));
      rst = 1'b1;
      set_in = '0;
      pps_in = 1'b0;
      rx_in = '0;
      tx_in = '0;
      run_rx = 1'b0;
      run_tx = 1'b0;
      gpio_in = '0;
      cycle_cnt = 0;
      pps_gap = 0;
      for (int cyc = 0; cyc < RST_CYCLES + NUM_CYCLES; cyc++) begin
         @(posedge bus_clk);
         model_step();
         drive_inputs(cyc);
         @(negedge bus_clk);
         check_iq("o_tx", m_tx, o_tx);
         check_iq("o_rx_fe", m_rx_fe, o_rx_fe);
         check_gpio("o_fe_gpio", m_gpio, o_fe_gpio);
         check_time("o_vita_time", m_time, o_vita_time);
         check_rb("o_rb_data", m_rb, o_rb_data);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: radio_ctrl.f
+incdir+include
logic/radio_bus_pkg.sv
logic/radio_fe_pkg.sv
logic/radio_settings.sv
logic/timekeeper.sv
logic/gpio_atr.sv
logic/fe_sample_path.sv
logic/readback_mux.sv
logic/radio_ctrl_top.sv
testbench/radio_ctrl_tb.sv

// File: Bender.yml
package:
  name: radio_ctrl

sources:
  - include_dirs:
      - include
    files:
      - logic/radio_bus_pkg.sv
      - logic/radio_fe_pkg.sv
      - logic/radio_settings.sv
      - logic/timekeeper.sv
      - logic/gpio_atr.sv
      - logic/fe_sample_path.sv
      - logic/readback_mux.sv
      - logic/radio_ctrl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/radio_ctrl_tb.sv
